// ==== flist.f ====
+incdir+.
tama_pkg.sv
clock_enable_gen.sv
rom_store.sv
image_write_router.sv
cpu_io_conditioner.sv
tama_support_top.sv
tama_support_checker.sv
tb_tama_support.sv

// ==== Bender.yml ====
package:
  name: tama_support

sources:
  - include_dirs:
      - .
    files:
      - tama_pkg.sv
      - clock_enable_gen.sv
      - rom_store.sv
      - image_write_router.sv
      - cpu_io_conditioner.sv
      - tama_support_top.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - tama_support_checker.sv
      - tb_tama_support.sv

// ==== tb_tama_support.sv ====
// testbench for the support logic around the emulator core
// expected values come from the loader, divider, key and sound rules
// image writes are compared in order against a queue of expected writes
// run length is bounded by a cycle counter

`timescale 1ns/1ps

`include "tama_defines.svh"

module tb_tama_support import tama_pkg::*; ();

  // limit about three times the longest run of roughly 1300 cycles
  localparam int max_cycles   = 4000;
  localparam int rom_words    = 32;
  localparam int bg_words     = 24;
  localparam int sprite_words = 16;
  localparam int key_steps    = 20;

  logic          clk_32_768;
  logic          reset;
  logic          load_wr;
  load_addr_t    load_addr;
  load_word_t    load_data;
  slot_id_t      slot_id;
  logic          set_wr;
  logic [31:0]   set_addr;
  logic [31:0]   set_data;
  key_bits_t     cont_key;
  rom_addr_t     rom_addr;
  logic          buzzer;
  rom_data_t     rom_data;
  logic          image_wr;
  image_addr_t   image_addr;
  load_word_t    image_data;
  logic          cpu_en;
  logic          cpu_en_2x;
  logic [3:0]    cpu_keys;
  audio_sample_t audio_sample;

  int          cycle_count = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          failed_tests = 0;
  int          test_errors_start = 0;
  string       test_name = "reset";
  logic [32:0] exp_q[$];
  logic [32:0] expected_write;

  tama_support_top UUT (.*);

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // kind 0 background, 1 spritesheet full word, 2 spritesheet high byte
  function automatic logic [32:0] exp_image(input int kind, input load_addr_t addr,
                                            input load_word_t data);
    image_addr_t a;
    load_word_t  d;
    if (kind == 0) begin
      a = addr[17:1];
      d = {data[7:0], data[15:8]};
    end else if (kind == 1) begin
      a = addr[16:0];
      d = data;
    end else begin
      a = addr[16:0] + 17'd1;
      d = {8'h00, data[15:8]};
    end
    return {a, d};
  endfunction

  // low 12 bits of the swapped word
  function automatic rom_data_t exp_rom(input load_word_t data);
    load_word_t swapped;
    swapped = {data[7:0], data[15:8]};
    return swapped[11:0];
  endfunction

  // face y, b, a to active low nibble
  function automatic logic [3:0] exp_keys(input key_bits_t k);
    return {1'b0, ~k[7], ~k[5], ~k[4]};
  endfunction

  function automatic audio_sample_t exp_sample(input logic mute, input logic buzz);
    return mute ? 15'd0 : {1'b0, {14{buzz}}};
  endfunction

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_errors_start = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == test_errors_start) begin
      $display("test %s: passed", test_name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", test_name,
               error_count - test_errors_start);
    end
  endtask

  // one strobe followed by an idle cycle
  task automatic send_word(input slot_id_t slot, input load_addr_t addr,
                           input load_word_t data);
    @(posedge clk_32_768);
    load_wr   <= 1'b1;
    slot_id   <= slot;
    load_addr <= addr;
    load_data <= data;
    @(posedge clk_32_768);
    load_wr   <= 1'b0;
  endtask

  task automatic write_setting(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_32_768);
    set_wr   <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    @(posedge clk_32_768);
    set_wr   <= 1'b0;
  endtask

  // wait for queued image writes and a few quiet cycles
  task automatic drain_image_writes();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 16) begin
      @(negedge clk_32_768);
      waited++;
    end
    repeat (4) @(negedge clk_32_768);
    if (exp_q.size() != 0) begin
      error_count++;
      $display("error in %s: %0d expected image writes never appeared",
               test_name, exp_q.size());
      exp_q.delete();
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic run_enable_test();
    int gap;
    int pulses_2x;
    begin_test("clock_enables");
    // reset dropped on the previous edge
    gap = 0;
    do begin
      @(posedge clk_32_768);
      gap++;
      @(negedge clk_32_768);
    end while (!cpu_en && gap < 1000);
    check_value({test_name, " first_cpu_en"}, 401, gap);
    gap       = 0;
    pulses_2x = 0;
    do begin
      @(posedge clk_32_768);
      gap++;
      @(negedge clk_32_768);
      if (cpu_en_2x) begin
        pulses_2x++;
      end
    end while (!cpu_en && gap < 1000);
    check_value({test_name, " cpu_en_period"}, 401, gap);
    check_value({test_name, " cpu_en_2x_per_period"}, 2, pulses_2x);
    end_test();
  endtask

  task automatic run_rom_test();
    load_addr_t  addrs[rom_words];
    load_word_t  words[rom_words];
    logic [31:0] r;
    begin_test("rom_load_read");
    for (int i = 0; i < rom_words; i++) begin
      // low word address bits from i keep the addresses distinct
      r        = $urandom;
      addrs[i] = {r[14:0], i[4:0], 1'b0};
      r        = $urandom;
      words[i] = r[15:0];
      send_word(`TAMA_SLOT_ROM, addrs[i], words[i]);
    end
    for (int i = rom_words - 1; i >= 0; i--) begin
      @(posedge clk_32_768);
      rom_addr <= addrs[i][13:1];
      @(posedge clk_32_768);
      @(negedge clk_32_768);
      check_value(test_name, exp_rom(words[i]), rom_data);
    end
    end_test();
  endtask

  task automatic run_background_test();
    logic [31:0] r;
    logic [31:0] d;
    begin_test("background_writes");
    for (int i = 0; i < bg_words; i++) begin
      r = $urandom;
      d = $urandom;
      exp_q.push_back(exp_image(0, r[20:0], d[15:0]));
      send_word(`TAMA_SLOT_BACKGROUND, r[20:0], d[15:0]);
    end
    drain_image_writes();
    end_test();
  endtask

  task automatic run_sprite_test();
    logic [31:0] r;
    logic [31:0] d;
    begin_test("spritesheet_writes");
    for (int i = 0; i < sprite_words; i++) begin
      r = $urandom;
      d = $urandom;
      exp_q.push_back(exp_image(1, r[20:0], d[15:0]));
      exp_q.push_back(exp_image(2, r[20:0], d[15:0]));
      send_word(`TAMA_SLOT_SPRITESHEET, r[20:0], d[15:0]);
      // slots 12 and up never reach the image port
      r = $urandom;
      send_word(16'd12 + r[6:0], r[20:0], d[31:16]);
    end
    drain_image_writes();
    end_test();
  endtask

  task automatic run_key_test();
    key_bits_t k;
    key_bits_t prev_k;
    begin_test("keys");
    prev_k = cont_key;
    for (int i = 0; i < key_steps; i++) begin
      k = $urandom;
      @(posedge clk_32_768);
      cont_key <= k;
      // old keys still at the output after two stages
      repeat (2) @(posedge clk_32_768);
      @(negedge clk_32_768);
      check_value({test_name, " early"}, exp_keys(prev_k), cpu_keys);
      // third synchronizer stage
      @(posedge clk_32_768);
      @(negedge clk_32_768);
      check_value(test_name, exp_keys(k), cpu_keys);
      prev_k = k;
    end
    end_test();
  endtask

  task automatic run_sound_test();
    logic        mute;
    logic        buzz;
    logic [31:0] r;
    begin_test("sound");
    for (int s = 0; s < 4; s++) begin
      mute = s[0];
      r    = $urandom;
      // upper data bits are ignored
      write_setting(`TAMA_SETTING_SOUND_ADDR, {r[31:1], mute});
      // other settings address leaves the mute bit alone
      write_setting(32'h14, {r[31:1], ~mute});
      for (int b = 0; b < 4; b++) begin
        buzz = b[0];
        @(posedge clk_32_768);
        buzzer <= buzz;
        @(posedge clk_32_768);
        @(negedge clk_32_768);
        check_value(test_name, exp_sample(mute, buzz), audio_sample);
      end
    end
    end_test();
  endtask

  ////////////////////////////////////////
  // clock, monitor, timeout
  ////////////////////////////////////////

  initial begin
    clk_32_768 = 1'b0;
    forever #5 clk_32_768 = ~clk_32_768;
  end

  // every image write is matched in order
  always @(negedge clk_32_768) begin
    if (!reset && image_wr) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("error in %s: image write to %0h when none was expected",
                 test_name, image_addr);
      end else begin
        expected_write = exp_q.pop_front();
        check_value(test_name, expected_write, {image_addr, image_data});
      end
    end
  end

  always @(posedge clk_32_768) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    r_seed_init();
    reset     = 1'b1;
    load_wr   = 1'b0;
    load_addr = '0;
    load_data = '0;
    slot_id   = '0;
    set_wr    = 1'b0;
    set_addr  = '0;
    set_data  = '0;
    cont_key  = '0;
    rom_addr  = '0;
    buzzer    = 1'b0;
    repeat (10) @(posedge clk_32_768);
    reset <= 1'b0;

    run_enable_test();
    run_rom_test();
    run_background_test();
    run_sprite_test();
    run_key_test();
    run_sound_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // one seed for the whole run
  task automatic r_seed_init();
    int unsigned seed;
    int unsigned discard;
    seed    = 32'hb642_c0c2;
    discard = $urandom(seed);
  endtask

endmodule

// ==== tama_support_checker.sv ====
// concurrent checks on the cpu enables and the image write port
// bound into tama_support_top, port names match the top level
// spritesheet strobes need an idle cycle between them

`timescale 1ns/1ps

`include "tama_defines.svh"

module tama_support_checker import tama_pkg::*; (
  input logic     clk_32_768,
  input logic     reset,
  input logic     cpu_en,
  input logic     cpu_en_2x,
  input logic     image_wr,
  input logic     load_wr,
  input slot_id_t slot_id
);

  logic sprite_strobe;

  assign sprite_strobe = load_wr && (slot_id == `TAMA_SLOT_SPRITESHEET);

  ////////////////////////////////////////
  // enables
  ////////////////////////////////////////

  // every cpu tick is also a 2x tick
  en_implies_2x: assert property (@(posedge clk_32_768) disable iff (reset)
    cpu_en |-> cpu_en_2x)
    else $error("cpu_en without cpu_en_2x");

  // single-cycle pulses, period far longer than 2
  en_single_pulse: assert property (@(posedge clk_32_768) disable iff (reset)
    cpu_en |=> !cpu_en)
    else $error("cpu_en high on two consecutive cycles");

  ////////////////////////////////////////
  // image port and loader
  ////////////////////////////////////////

  // one reset edge clears the write strobe
  image_quiet_in_reset: assert property (@(posedge clk_32_768)
    $past(reset) |-> !image_wr)
    else $error("image_wr high during reset");

  sprite_gap: assert property (@(posedge clk_32_768) disable iff (reset)
    sprite_strobe |=> !sprite_strobe)
    else $error("spritesheet strobes back to back");

endmodule

bind tama_support_top tama_support_checker u_tama_support_checker (.*);

// ==== tama_support_top.sv ====
// support logic around the emulator core: rom, image loader, enables, i/o
// all ports synchronous to clk_32_768, reset synchronous active high
// no registers here, timing comes from the workers
// cpu and video blocks attach at the rom, image and enable ports

`timescale 1ns/1ps

module tama_support_top import tama_pkg::*; (
  input  logic          clk_32_768,
  input  logic          reset,

  // loader stream
  input  logic          load_wr,
  input  load_addr_t    load_addr,
  input  load_word_t    load_data,
  input  slot_id_t      slot_id,

  // settings writes
  input  logic          set_wr,
  input  logic [31:0]   set_addr,
  input  logic [31:0]   set_data,

  // controller
  input  key_bits_t     cont_key,

  // cpu side
  input  rom_addr_t     rom_addr,
  input  logic          buzzer,
  output rom_data_t     rom_data,
  output logic          cpu_en,
  output logic          cpu_en_2x,
  output logic [3:0]    cpu_keys,

  // video image memories
  output logic          image_wr,
  output image_addr_t   image_addr,
  output load_word_t    image_data,

  output audio_sample_t audio_sample
);

  ////////////////////////////////////////
  // cpu clock enables
  ////////////////////////////////////////

  clock_enable_gen u_clock_enable_gen (
    .clk_32_768 (clk_32_768),
    .reset      (reset),
    .cpu_en     (cpu_en),
    .cpu_en_2x  (cpu_en_2x)
  );

  ////////////////////////////////////////
  // loader consumers
  ////////////////////////////////////////

  // slot 0
  rom_store u_rom_store (
    .clk_32_768 (clk_32_768),
    .load_wr    (load_wr),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .slot_id    (slot_id),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data)
  );

  // slots 10 and 11
  image_write_router u_image_write_router (
    .clk_32_768 (clk_32_768),
    .reset      (reset),
    .load_wr    (load_wr),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .slot_id    (slot_id),
    .image_wr   (image_wr),
    .image_addr (image_addr),
    .image_data (image_data)
  );

  ////////////////////////////////////////
  // keys and sound
  ////////////////////////////////////////

  cpu_io_conditioner u_cpu_io_conditioner (
    .clk_32_768   (clk_32_768),
    .reset        (reset),
    .cont_key     (cont_key),
    .set_wr       (set_wr),
    .set_addr     (set_addr),
    .set_data     (set_data),
    .buzzer       (buzzer),
    .cpu_keys     (cpu_keys),
    .audio_sample (audio_sample)
  );

endmodule

// ==== cpu_io_conditioner.sv ====
// key synchronizer, face key mapping and gated buzzer sample
// cpu_keys lags cont_key by 3 cycles, audio_sample lags by 1
// only bit 0 of the sound setting word is kept

`timescale 1ns/1ps

`include "tama_defines.svh"

module cpu_io_conditioner import tama_pkg::*; (
  input  logic          clk_32_768,
  input  logic          reset,
  input  key_bits_t     cont_key,
  input  logic          set_wr,
  input  logic [31:0]   set_addr,
  input  logic [31:0]   set_data,
  input  logic          buzzer,
  output logic [3:0]    cpu_keys,
  output audio_sample_t audio_sample
);

  // synchronizer stages, first to last
  key_bits_t key_s1;
  key_bits_t key_s2;
  key_bits_t key_s3;

  logic      sound_disable;

  always_ff @(posedge clk_32_768) begin
    key_s1 <= cont_key;
    key_s2 <= key_s1;
    key_s3 <= key_s2;
  end

  // left, middle, right buttons, active low at the cpu
  // key 7 face_y, key 5 face_b, key 4 face_a
  assign cpu_keys = {1'b0, ~key_s3[7], ~key_s3[5], ~key_s3[4]};

  // sound setting register and sample
  always_ff @(posedge clk_32_768) begin
    if (reset) begin
      sound_disable <= 1'b0;
      audio_sample  <= '0;
    end else begin
      if (set_wr && (set_addr == `TAMA_SETTING_SOUND_ADDR)) begin
        sound_disable <= set_data[0];
      end
      // square wave at half scale, sign bit clear
      audio_sample <= sound_disable ? '0 : {1'b0, {(`TAMA_AUDIO_W-1){buzzer}}};
    end
  end

endmodule

// ==== image_write_router.sv ====
// routes background and spritesheet loader words to one image write port
// background: one write, word address, bytes swapped
// spritesheet: full word at A, then high byte alone at A + 1 a cycle later
// source must leave an idle cycle after each spritesheet word;
// a strobe landing on the trailing write cycle is dropped

`timescale 1ns/1ps

`include "tama_defines.svh"

module image_write_router import tama_pkg::*; (
  input  logic        clk_32_768,
  input  logic        reset,
  input  logic        load_wr,
  input  load_addr_t  load_addr,
  input  load_word_t  load_data,
  input  slot_id_t    slot_id,
  output logic        image_wr,
  output image_addr_t image_addr,
  output load_word_t  image_data
);

  ////////////////////////////////////////
  // slot decode
  ////////////////////////////////////////

  logic        bg_load;
  logic        sprite_load;

  // addresses for each path
  image_addr_t bg_addr;
  image_addr_t sprite_addr;

  // trailing high-byte write
  logic        high_pend;
  logic [7:0]  high_byte;
  image_addr_t high_addr;

  assign bg_load     = load_wr && (slot_id == `TAMA_SLOT_BACKGROUND);
  assign sprite_load = load_wr && (slot_id == `TAMA_SLOT_SPRITESHEET);

  // background is word addressed
  assign bg_addr     = load_addr[`TAMA_IMAGE_ADDR_W:1];
  // spritesheet keeps the byte address, one pixel per write
  assign sprite_addr = load_addr[`TAMA_IMAGE_ADDR_W-1:0];

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge clk_32_768) begin
    if (reset) begin
      image_wr  <= 1'b0;
      high_pend <= 1'b0;
    end else begin
      // the pending high byte finishes its pair first
      image_wr  <= high_pend || bg_load || sprite_load;
      high_pend <= !high_pend && sprite_load;
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge clk_32_768) begin
    if (high_pend) begin
      // second half of a spritesheet word
      image_addr <= high_addr;
      image_data <= {8'h00, high_byte};
    end else if (sprite_load) begin
      image_addr <= sprite_addr;
      image_data <= load_data;
    end else if (bg_load) begin
      image_addr <= bg_addr;
      image_data <= swap_bytes(load_data);
    end

    // latch high byte and next address with every spritesheet word
    if (sprite_load) begin
      high_byte <= load_data[15:8];
      high_addr <= sprite_addr + 1'b1;
    end
  end

endmodule

// ==== rom_store.sv ====
// program rom, loaded from slot 0 of the loader stream
// loader byte address bit 0 is ignored, words land at load_addr[13:1]
// read data is registered, one cycle after rom_addr
// contents are undefined until loaded

`timescale 1ns/1ps

`include "tama_defines.svh"

module rom_store import tama_pkg::*; (
  input  logic       clk_32_768,
  input  logic       load_wr,
  input  load_addr_t load_addr,
  input  load_word_t load_data,
  input  slot_id_t   slot_id,
  input  rom_addr_t  rom_addr,
  output rom_data_t  rom_data
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // full 16-bit words kept, cpu only sees the low 12
  load_word_t rom_mem [`TAMA_ROM_DEPTH];

  // read register, zero at configuration
  rom_data_t  read_q = '0;

  logic       rom_load;
  rom_addr_t  load_word_addr;

  // only the rom slot writes here
  assign rom_load       = load_wr && (slot_id == `TAMA_SLOT_ROM);
  // byte to word address
  assign load_word_addr = load_addr[`TAMA_ROM_ADDR_W:1];

  ////////////////////////////////////////
  // load and read ports
  ////////////////////////////////////////

  // write lands on the strobe edge
  always_ff @(posedge clk_32_768) begin
    if (rom_load) begin
      rom_mem[load_word_addr] <= swap_bytes(load_data);
    end
  end

  // instruction fetch, one cycle latency
  always_ff @(posedge clk_32_768) begin
    read_q <= rom_mem[rom_addr][`TAMA_ROM_DATA_W-1:0];
  end

  assign rom_data = read_q;

endmodule

// ==== clock_enable_gen.sv ====
// cpu enable and double-rate enable from one down-counter
// cpu_en period is reload + 1 cycles, cpu_en_2x adds a pulse at half count
// both enables are single-cycle pulses, low while reset is high

`timescale 1ns/1ps

`include "tama_defines.svh"

module clock_enable_gen import tama_pkg::*; (
  input  logic clk_32_768,
  input  logic reset,
  output logic cpu_en,
  output logic cpu_en_2x
);

  // mid-period point for the extra 2x pulse
  localparam div_count_t half_count = `TAMA_CLK_DIV_RELOAD / 2;

  div_count_t div_count;

  always_ff @(posedge clk_32_768) begin
    if (reset) begin
      div_count <= `TAMA_CLK_DIV_RELOAD;
      cpu_en    <= 1'b0;
      cpu_en_2x <= 1'b0;
    end else begin
      // pulses by default
      cpu_en    <= 1'b0;
      cpu_en_2x <= 1'b0;

      if (div_count == '0) begin
        // end of period, both rates tick
        div_count <= `TAMA_CLK_DIV_RELOAD;
        cpu_en    <= 1'b1;
        cpu_en_2x <= 1'b1;
      end else begin
        div_count <= div_count - 1'b1;
        // half way, 2x rate only
        if (div_count == half_count) begin
          cpu_en_2x <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== tama_pkg.sv ====
// types shared by the support logic, sized from the defines header
// loader addresses are byte addresses; rom and image ports are word based

`include "tama_defines.svh"

package tama_pkg;

  // loader stream
  typedef logic [`TAMA_LOAD_WORD_W-1:0] load_word_t;
  typedef logic [`TAMA_LOAD_ADDR_W-1:0] load_addr_t;
  typedef logic [15:0]                  slot_id_t;

  // program rom
  typedef logic [`TAMA_ROM_ADDR_W-1:0]  rom_addr_t;
  typedef logic [`TAMA_ROM_DATA_W-1:0]  rom_data_t;

  // top bit picks background or spritesheet memory
  typedef logic [`TAMA_IMAGE_ADDR_W-1:0] image_addr_t;

  typedef logic [`TAMA_AUDIO_W-1:0]     audio_sample_t;
  typedef logic [15:0]                  key_bits_t;
  typedef logic [`TAMA_CLK_DIV_W-1:0]   div_count_t;

  // loader words arrive big endian, memories want them swapped
  function automatic load_word_t swap_bytes(input load_word_t word);
    return {word[7:0], word[15:8]};
  endfunction

endpackage

// ==== tama_defines.svh ====
// widths, counts and decode constants shared by the support logic
// slot ids are 16-bit to match the loader slot field
// divider reload sets the cpu enable period to reload + 1 cycles

`ifndef TAMA_DEFINES_SVH
`define TAMA_DEFINES_SVH

// cpu enable divider
`define TAMA_CLK_DIV_W          10
`define TAMA_CLK_DIV_RELOAD     10'd400

// loader data slots
`define TAMA_SLOT_ROM           16'd0
`define TAMA_SLOT_BACKGROUND    16'd10
`define TAMA_SLOT_SPRITESHEET   16'd11

// program rom, word addressed
`define TAMA_ROM_DEPTH          8192
`define TAMA_ROM_ADDR_W         13
`define TAMA_ROM_DATA_W         12

// loader stream and image port
`define TAMA_LOAD_WORD_W        16
`define TAMA_LOAD_ADDR_W        21
`define TAMA_IMAGE_ADDR_W       17

`define TAMA_AUDIO_W            15
`define TAMA_SETTING_SOUND_ADDR 32'h10

`endif
